//--- rtl/cpu_pkg.sv
package cpu_pkg;

  localparam int data_w = 4;

  // Microcode ROM geometry
  localparam int urom_depth = 32;
  localparam int uaddr_w = 5;
  localparam int uword_w = 16;

  typedef enum logic [2:0] {
    REG_NONE = 3'd0,
    REG_A    = 3'd1,
    REG_B    = 3'd2,
    REG_IMM  = 3'd3,
    REG_ALU  = 3'd4
  } reg_type;

  typedef enum logic [1:0] {
    ALU_ADD  = 2'd0,
    ALU_SUB  = 2'd1,
    ALU_XOR  = 2'd2,
    ALU_PASS = 2'd3
  } alu_op;

  // Micro word fields
  //   [15:13] micro-opcode
  //   TRANSFER  [12:10] source, [9:7] destination
  //   TRANSALU  [12:11] ALU operation, [9:7] destination, flags written
  //   JMP       [12] conditional, [11] zero value to match, [4:0] target
  typedef enum logic [2:0] {
    MOP_NOP      = 3'd0,
    MOP_TRANSFER = 3'd1,
    MOP_TRANSALU = 3'd2,
    MOP_SETPC    = 3'd3,
    MOP_JMP      = 3'd4,
    MOP_END      = 3'd5,
    MOP_HALT     = 3'd7
  } micro_op;

  typedef enum logic [2:0] {
    OP_LDA   = 3'd0,
    OP_LDB   = 3'd1,
    OP_ADD   = 3'd2,
    OP_SUB   = 3'd3,
    OP_XOR   = 3'd4,
    OP_MOVBA = 3'd5,
    OP_JNZ   = 3'd6,
    OP_HALT  = 3'd7
  } macro_op;

  // Datapath controls for one cycle
  typedef struct packed {
    reg_type src;
    reg_type dst;
    alu_op   alu;
    logic    flag_we;
    logic    set_pc;
    logic    fetch;
  } dp_ctrl;

endpackage

//--- rtl/mem_pkg.sv
package mem_pkg;

  localparam int addr_w = 8;
  localparam int word_w = 8;
  localparam int mem_depth = 256;

  // APB side
  localparam int paddr_w = 9;
  localparam int apb_w = 32;
  localparam logic [paddr_w-1:0] ctrl_addr = 9'd256;

  // Status word layout
  localparam int st_a_lsb = 0;
  localparam int st_b_lsb = 4;
  localparam int st_zero = 8;
  localparam int st_carry = 9;
  localparam int st_halted = 10;
  localparam int st_pc_lsb = 11;
  localparam int status_w = 19;

endpackage

//--- rtl/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
  import mem_pkg::*;

  logic              req;
  logic              we;
  logic [addr_w-1:0] addr;
  logic [word_w-1:0] wdata;
  logic [word_w-1:0] rdata;
  logic              ready;

  // Request fields stay stable until ready
  modport requester (output req, output we, output addr, output wdata,
                     input rdata, input ready);

  modport responder (input req, input we, input addr, input wdata,
                     output rdata, output ready);

endinterface

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [cpu_pkg::data_w-1:0] a,
  input  logic [cpu_pkg::data_w-1:0] b,
  input  cpu_pkg::alu_op             sel,
  output logic [cpu_pkg::data_w-1:0] result,
  output logic                       carry,
  output logic                       zero
);
  import cpu_pkg::*;

  logic [data_w:0] wide;

  always_comb begin
    case (sel)
      ALU_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
      end
      ALU_SUB: begin
        // Top bit doubles as borrow
        wide = {1'b0, a} - {1'b0, b};
      end
      ALU_XOR: begin
        wide = {1'b0, a ^ b};
      end
      default: begin
        wide = {1'b0, a};
      end
    endcase
  end

  assign result = wide[data_w-1:0];
  assign carry = wide[data_w];
  assign zero = (result == '0);

endmodule

//--- rtl/microcode.sv
`timescale 1ns/1ps

module microcode (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             start,
  input  cpu_pkg::macro_op opcode,
  input  logic             zero,
  input  logic             fetch_done,
  output cpu_pkg::dp_ctrl  ctrl,
  output logic             halted
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DECODE,
    EXECUTE
  } stage_t;

  logic [uword_w-1:0] rom [urom_depth];

  initial $readmemh("rtl/microcode.hex", rom);

  stage_t             stage;
  logic [uaddr_w-1:0] micro_pc;
  logic [uword_w-1:0] word;
  micro_op            mop;
  logic               jmp_taken;
  logic [uaddr_w-1:0] jmp_target;

  assign word = rom[micro_pc];
  assign mop = micro_op'(word[15:13]);

  // Unconditional, or zero flag matches bit 11
  assign jmp_taken = (mop == MOP_JMP) && (!word[12] || (word[11] == zero));
  assign jmp_target = word[uaddr_w-1:0];

  always_comb begin
    ctrl.src = REG_NONE;
    ctrl.dst = REG_NONE;
    ctrl.alu = ALU_PASS;
    ctrl.flag_we = 1'b0;
    ctrl.set_pc = 1'b0;
    ctrl.fetch = 1'b0;

    case (stage)
      FETCH: begin
        ctrl.fetch = 1'b1;
      end
      EXECUTE: begin
        case (mop)
          MOP_TRANSFER: begin
            ctrl.src = reg_type'(word[12:10]);
            ctrl.dst = reg_type'(word[9:7]);
          end
          MOP_TRANSALU: begin
            ctrl.src = REG_ALU;
            ctrl.dst = reg_type'(word[9:7]);
            ctrl.alu = alu_op'(word[12:11]);
            ctrl.flag_we = 1'b1;
          end
          MOP_SETPC: begin
            ctrl.set_pc = 1'b1;
          end
          default: begin
          end
        endcase
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      stage <= IDLE;
      micro_pc <= '0;
      halted <= 1'b1;
    end else if (start) begin
      stage <= FETCH;
      halted <= 1'b0;
    end else begin
      case (stage)
        FETCH: begin
          if (fetch_done) begin
            stage <= DECODE;
          end
        end
        DECODE: begin
          // Four micro words per macro opcode
          micro_pc <= {opcode, 2'b00};
          stage <= EXECUTE;
        end
        EXECUTE: begin
          micro_pc <= jmp_taken ? jmp_target : micro_pc + uaddr_w'(1);
          if (mop == MOP_END) begin
            stage <= FETCH;
          end else if (mop == MOP_HALT) begin
            stage <= IDLE;
            halted <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         start,
  input  cpu_pkg::dp_ctrl              ctrl,
  input  logic [cpu_pkg::data_w-1:0]   alu_result,
  input  logic                         alu_carry,
  input  logic                         alu_zero,
  output logic [cpu_pkg::data_w-1:0]   alu_a,
  output logic [cpu_pkg::data_w-1:0]   alu_b,
  output cpu_pkg::alu_op               alu_sel,
  output cpu_pkg::macro_op             opcode,
  output logic                         zero,
  output logic                         fetch_done,
  mem_if.requester                     fetch,
  output logic [mem_pkg::status_w-1:0] status
);
  import cpu_pkg::*;
  import mem_pkg::*;

  logic [addr_w-1:0] pc_q;
  logic [word_w-1:0] ir_q;
  logic [data_w-1:0] a_q;
  logic [data_w-1:0] b_q;
  logic [data_w-1:0] bus;
  logic              zero_q;
  logic              carry_q;

  // Instruction fetch held at the PC until ready
  assign fetch.req = ctrl.fetch;
  assign fetch.we = 1'b0;
  assign fetch.addr = pc_q;
  assign fetch.wdata = '0;
  assign fetch_done = ctrl.fetch && fetch.ready;

  assign opcode = macro_op'(ir_q[7:5]);
  assign zero = zero_q;
  assign alu_a = a_q;
  assign alu_b = b_q;
  assign alu_sel = ctrl.alu;

  always_comb begin
    case (ctrl.src)
      REG_A:   bus = a_q;
      REG_B:   bus = b_q;
      REG_IMM: bus = ir_q[data_w-1:0];
      REG_ALU: bus = alu_result;
      default: bus = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n || start) begin
      // A new run starts from a clean register file
      pc_q <= '0;
      a_q <= '0;
      b_q <= '0;
      zero_q <= 1'b0;
      carry_q <= 1'b0;
    end else begin
      if (fetch_done) begin
        pc_q <= pc_q + addr_w'(1);
      end else if (ctrl.set_pc) begin
        pc_q <= addr_w'(ir_q[4:0]);
      end
      if (ctrl.dst == REG_A) begin
        a_q <= bus;
      end
      if (ctrl.dst == REG_B) begin
        b_q <= bus;
      end
      if (ctrl.flag_we) begin
        zero_q <= alu_zero;
        // XOR keeps the old carry
        if (ctrl.alu != ALU_XOR) begin
          carry_q <= alu_carry;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      ir_q <= fetch.rdata;
    end
  end

  // Halted bit is merged in by the host bridge
  always_comb begin
    status = '0;
    status[st_a_lsb +: data_w] = a_q;
    status[st_b_lsb +: data_w] = b_q;
    status[st_zero] = zero_q;
    status[st_carry] = carry_q;
    status[st_pc_lsb +: addr_w] = pc_q;
  end

endmodule

//--- rtl/prog_store.sv
`timescale 1ns/1ps

module prog_store (
  input  logic      clk,
  input  logic      reset_n,
  mem_if.responder  fetch_port,
  mem_if.responder  host_port
);
  import mem_pkg::*;

  logic [word_w-1:0] mem [mem_depth];
  logic              last_host;
  logic              fetch_ready_q;
  logic              host_ready_q;
  logic [word_w-1:0] fetch_rdata_q;
  logic [word_w-1:0] host_rdata_q;
  logic              fetch_elig;
  logic              host_elig;
  logic              grant_fetch;
  logic              grant_host;
  logic [addr_w-1:0] sel_addr;
  logic [word_w-1:0] sel_wdata;
  logic              sel_we;

  // A port in its response cycle cannot be granted again
  assign fetch_elig = fetch_port.req && !fetch_ready_q;
  assign host_elig = host_port.req && !host_ready_q;

  // Round robin on contention
  assign grant_fetch = fetch_elig && (!host_elig || last_host);
  assign grant_host = host_elig && !grant_fetch;

  assign sel_addr = grant_host ? host_port.addr : fetch_port.addr;
  assign sel_wdata = grant_host ? host_port.wdata : fetch_port.wdata;
  assign sel_we = (grant_host && host_port.we) || (grant_fetch && fetch_port.we);

  assign fetch_port.ready = fetch_ready_q;
  assign fetch_port.rdata = fetch_rdata_q;
  assign host_port.ready = host_ready_q;
  assign host_port.rdata = host_rdata_q;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      last_host <= 1'b0;
      fetch_ready_q <= 1'b0;
      host_ready_q <= 1'b0;
    end else begin
      fetch_ready_q <= grant_fetch;
      host_ready_q <= grant_host;
      if (grant_fetch || grant_host) begin
        last_host <= grant_host;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel_we) begin
      mem[sel_addr] <= sel_wdata;
    end
    if (grant_fetch) begin
      fetch_rdata_q <= mem[sel_addr];
    end
    if (grant_host) begin
      host_rdata_q <= mem[sel_addr];
    end
  end

endmodule

//--- rtl/host_bridge.sv
`timescale 1ns/1ps

module host_bridge (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [mem_pkg::paddr_w-1:0]  paddr,
  input  logic [mem_pkg::apb_w-1:0]    pwdata,
  output logic [mem_pkg::apb_w-1:0]    prdata,
  output logic                         pready,
  input  logic [mem_pkg::status_w-1:0] status,
  input  logic                         halted,
  output logic                         start,
  mem_if.requester                     mem
);
  import mem_pkg::*;

  logic             setup;
  logic             access;
  logic             mem_sel;
  logic             ctrl_sel;
  logic [apb_w-1:0] status_word;

  assign setup = psel && !penable;
  assign access = psel && penable;

  // Program memory occupies the lower 256 addresses
  assign mem_sel = !paddr[addr_w];
  assign ctrl_sel = (paddr == ctrl_addr);

  assign mem.req = access && mem_sel;
  assign mem.we = pwrite;
  assign mem.addr = paddr[addr_w-1:0];
  assign mem.wdata = pwdata[word_w-1:0];

  assign pready = mem.req ? mem.ready : 1'b1;

  always_comb begin
    status_word = '0;
    status_word[status_w-1:0] = status;
    status_word[st_halted] = halted;
  end

  always_comb begin
    if (ctrl_sel) begin
      prdata = status_word;
    end else if (mem_sel) begin
      prdata = apb_w'(mem.rdata);
    end else begin
      prdata = '0;
    end
  end

  // Captured in setup so the pulse lands in the access cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      start <= 1'b0;
    end else begin
      start <= setup && pwrite && ctrl_sel && pwdata[0];
    end
  end

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [mem_pkg::paddr_w-1:0] paddr,
  input  logic [mem_pkg::apb_w-1:0]   pwdata,
  output logic [mem_pkg::apb_w-1:0]   prdata,
  output logic                        pready,
  output logic                        halted
);
  import cpu_pkg::*;
  import mem_pkg::*;

  mem_if fetch_bus ();
  mem_if host_bus ();

  logic                start;
  dp_ctrl              ctrl;
  macro_op             opcode;
  logic                zero;
  logic                fetch_done;
  logic [data_w-1:0]   alu_a;
  logic [data_w-1:0]   alu_b;
  logic [data_w-1:0]   alu_result;
  alu_op               alu_sel;
  logic                alu_carry;
  logic                alu_zero;
  logic [status_w-1:0] status;

  host_bridge u_host_bridge (
    .clk     (clk),
    .reset_n (reset_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .status  (status),
    .halted  (halted),
    .start   (start),
    .mem     (host_bus)
  );

  microcode u_microcode (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .opcode     (opcode),
    .zero       (zero),
    .fetch_done (fetch_done),
    .ctrl       (ctrl),
    .halted     (halted)
  );

  datapath u_datapath (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .alu_carry  (alu_carry),
    .alu_zero   (alu_zero),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_sel    (alu_sel),
    .opcode     (opcode),
    .zero       (zero),
    .fetch_done (fetch_done),
    .fetch      (fetch_bus),
    .status     (status)
  );

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .sel    (alu_sel),
    .result (alu_result),
    .carry  (alu_carry),
    .zero   (alu_zero)
  );

  prog_store u_prog_store (
    .clk        (clk),
    .reset_n    (reset_n),
    .fetch_port (fetch_bus),
    .host_port  (host_bus)
  );

endmodule

//--- verif/cpu_top_tb.sv
`timescale 1ns/1ps

module cpu_top_tb;
  import cpu_pkg::*;
  import mem_pkg::*;

  localparam int apb_timeout = 64;
  localparam int halt_timeout = 20000;
  localparam int ref_step_limit = 100000;

  // Architectural state after a run
  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic              carry;
    logic              zero;
    logic [data_w-1:0] b;
    logic [data_w-1:0] a;
  } ref_state;

  logic               clk;
  logic               reset_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [paddr_w-1:0] paddr;
  logic [apb_w-1:0]   pwdata;
  logic [apb_w-1:0]   prdata;
  logic               pready;
  logic               halted;

  // Copy of what the host has written to program memory
  logic [word_w-1:0] image [mem_depth];
  logic [31:0]       lcg_state;
  logic [addr_w-1:0] rand_addr [16];
  logic [apb_w-1:0]  rd;
  logic [15:0]       rnd;
  logic [15:0]       rnd_arg;
  ref_state          exp_state;
  int                len;

  cpu_top uut (
    .clk     (clk),
    .reset_n (reset_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .halted  (halted)
  );

  always #4 clk = ~clk;

  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic logic [word_w-1:0] encode(macro_op op, logic [4:0] operand);
    return {op, operand};
  endfunction

  // Interprets the image with the macro instruction rules
  function automatic ref_state run_reference();
    ref_state          s;
    logic [word_w-1:0] ir;
    int                sum;
    int                steps;
    bit                done;
    s = '0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < ref_step_limit) begin
      ir = image[s.pc];
      s.pc = s.pc + addr_w'(1);
      steps++;
      case (macro_op'(ir[7:5]))
        OP_LDA: s.a = ir[3:0];
        OP_LDB: s.b = ir[3:0];
        OP_ADD: begin
          sum = int'(s.a) + int'(s.b);
          s.carry = (sum >= (1 << data_w));
          s.a = data_w'(sum);
          s.zero = (s.a == '0);
        end
        OP_SUB: begin
          // Borrow when the subtrahend is larger
          s.carry = (s.a < s.b);
          s.a = s.a - s.b;
          s.zero = (s.a == '0);
        end
        OP_XOR: begin
          s.a = s.a ^ s.b;
          s.zero = (s.a == '0);
        end
        OP_MOVBA: s.b = s.a;
        OP_JNZ: begin
          if (!s.zero) begin
            s.pc = {3'b000, ir[4:0]};
          end
        end
        default: done = 1'b1;
      endcase
    end
    return s;
  endfunction

  task automatic abort_run(input string reason);
    $display("Error: %s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("[FAIL] time %0t: %s expected 0x%0h, got 0x%0h", $time, field, exp, got);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string what, input logic [word_w-1:0] got,
                            input logic [word_w-1:0] exp);
    if (got !== exp) begin
      report_mismatch(what, 32'(exp), 32'(got));
    end
  endtask

  task automatic check_status(input string what, input logic [apb_w-1:0] got,
                              input ref_state exp, input logic exp_halted);
    if (got[st_a_lsb +: data_w] !== exp.a) begin
      report_mismatch({what, " A"}, 32'(exp.a), 32'(got[st_a_lsb +: data_w]));
    end
    if (got[st_b_lsb +: data_w] !== exp.b) begin
      report_mismatch({what, " B"}, 32'(exp.b), 32'(got[st_b_lsb +: data_w]));
    end
    if (got[st_zero] !== exp.zero) begin
      report_mismatch({what, " zero"}, 32'(exp.zero), 32'(got[st_zero]));
    end
    if (got[st_carry] !== exp.carry) begin
      report_mismatch({what, " carry"}, 32'(exp.carry), 32'(got[st_carry]));
    end
    if (got[st_halted] !== exp_halted) begin
      report_mismatch({what, " halted"}, 32'(exp_halted), 32'(got[st_halted]));
    end
    if (got[st_pc_lsb +: addr_w] !== exp.pc) begin
      report_mismatch({what, " PC"}, 32'(exp.pc), 32'(got[st_pc_lsb +: addr_w]));
    end
    if (got[apb_w-1:status_w] !== '0) begin
      report_mismatch({what, " unused bits"}, 32'(0), 32'(got[apb_w-1:status_w]));
    end
  endtask

  task automatic check_halted_pin(input string what, input logic exp);
    if (halted !== exp) begin
      report_mismatch(what, 32'(exp), 32'(halted));
    end
  endtask

  task automatic write_apb(input logic [paddr_w-1:0] addr, input logic [apb_w-1:0] data);
    int cycles;
    cycles = 0;
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      cycles++;
      if (cycles > apb_timeout) begin
        abort_run("APB write never saw pready");
      end
      @(negedge clk);
    end
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic read_apb(input logic [paddr_w-1:0] addr, output logic [apb_w-1:0] data);
    int cycles;
    cycles = 0;
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= addr;
    pwdata <= '0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      cycles++;
      if (cycles > apb_timeout) begin
        abort_run("APB read never saw pready");
      end
      @(negedge clk);
    end
    data = prdata;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic load_byte(input logic [addr_w-1:0] addr, input logic [word_w-1:0] data);
    image[addr] = data;
    write_apb({1'b0, addr}, 32'(data));
  endtask

  task automatic load_program(input int count);
    for (int i = 0; i < count; i++) begin
      write_apb(paddr_w'(i), 32'(image[i]));
    end
  endtask

  // Start pulse must drop halted on the next edge
  task automatic start_core();
    write_apb(ctrl_addr, 32'd1);
    @(negedge clk);
    check_halted_pin("halted pin after start", 1'b0);
  endtask

  task automatic wait_halted();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (halted !== 1'b1) begin
      cycles++;
      if (cycles > halt_timeout) begin
        abort_run("core did not halt in time");
      end
      @(negedge clk);
    end
  endtask

  task automatic run_and_check(input string name);
    ref_state         exp;
    logic [apb_w-1:0] status;
    exp = run_reference();
    start_core();
    wait_halted();
    read_apb(ctrl_addr, status);
    check_status(name, status, exp, 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    reset_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    lcg_state = 32'd5709;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    read_apb(ctrl_addr, rd);
    check_status("reset status", rd, ref_state'('0), 1'b1);
    check_halted_pin("halted pin after reset", 1'b1);

    // Random bytes at random addresses
    for (int i = 0; i < 16; i++) begin
      rnd = next_random();
      rnd_arg = next_random();
      rand_addr[i] = rnd[addr_w-1:0];
      load_byte(rand_addr[i], rnd_arg[word_w-1:0]);
    end
    for (int i = 0; i < 16; i++) begin
      read_apb({1'b0, rand_addr[i]}, rd);
      check_word($sformatf("readback at 0x%0h", rand_addr[i]), rd[word_w-1:0],
                 image[rand_addr[i]]);
    end

    // Overflow, borrow, xor to zero, then copy
    image[0] = encode(OP_LDA, 5'd9);
    image[1] = encode(OP_LDB, 5'd8);
    image[2] = encode(OP_ADD, 5'd0);
    image[3] = encode(OP_LDB, 5'd3);
    image[4] = encode(OP_SUB, 5'd0);
    image[5] = encode(OP_LDB, 5'd14);
    image[6] = encode(OP_XOR, 5'd0);
    image[7] = encode(OP_MOVBA, 5'd0);
    image[8] = encode(OP_HALT, 5'd0);
    load_program(9);
    run_and_check("fixed program");

    // Countdown
    image[0] = encode(OP_LDA, 5'd6);
    image[1] = encode(OP_LDB, 5'd1);
    image[2] = encode(OP_SUB, 5'd0);
    image[3] = encode(OP_JNZ, 5'd2);
    image[4] = encode(OP_HALT, 5'd0);
    load_program(5);
    run_and_check("countdown");
    read_apb(ctrl_addr, rd);
    check_word("countdown A", 8'(rd[st_a_lsb +: data_w]), 8'h00);
    check_word("countdown zero", 8'(rd[st_zero]), 8'h01);

    for (int p = 0; p < 20; p++) begin
      rnd = next_random();
      len = 3 + int'(rnd % 16'd8);
      for (int i = 0; i < len; i++) begin
        rnd = next_random();
        rnd_arg = next_random();
        image[i] = encode(macro_op'(3'(rnd % 16'd6)), rnd_arg[4:0]);
      end
      image[len] = encode(OP_HALT, 5'd0);
      load_program(len + 1);
      run_and_check($sformatf("random program %0d", p));
    end

    // Long loop with host reads while the core fetches
    image[0] = encode(OP_LDA, 5'd15);
    image[1] = encode(OP_LDB, 5'd1);
    image[2] = encode(OP_LDB, 5'd1);
    image[3] = encode(OP_LDB, 5'd1);
    image[4] = encode(OP_LDB, 5'd1);
    image[5] = encode(OP_SUB, 5'd0);
    image[6] = encode(OP_JNZ, 5'd2);
    image[7] = encode(OP_HALT, 5'd0);
    load_program(8);
    exp_state = run_reference();
    start_core();
    for (int k = 0; k < 40; k++) begin
      rnd = next_random();
      read_apb(paddr_w'(rnd[2:0]), rd);
      check_word($sformatf("read during run at 0x%0h", rnd[2:0]), rd[word_w-1:0],
                 image[rnd[2:0]]);
    end
    wait_halted();
    read_apb(ctrl_addr, rd);
    check_status("long loop", rd, exp_state, 1'b1);

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- rtl/microcode.hex
2C80
A000
0000
0000
2D00
A000
0000
0000
4080
A000
0000
0000
4880
A000
0000
0000
5080
A000
0000
0000
2500
A000
0000
0000
981A
6000
A000
0000
E000
0000
0000
0000

//--- cpu_top.f
rtl/cpu_pkg.sv
rtl/mem_pkg.sv
rtl/mem_if.sv
rtl/alu.sv
rtl/microcode.sv
rtl/datapath.sv
rtl/prog_store.sv
rtl/host_bridge.sv
rtl/cpu_top.sv
verif/cpu_top_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module cpu_top_tb \
  -f cpu_top.f -o cpu_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/cpu_top_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Test completed successfully"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
